// ==== pwm_timer_subsystem.f ====
verilog/apb_map_pkg.sv
verilog/pwm_timer_pkg.sv
verilog/apb_slot_decoder.sv
verilog/pwm_timer_channel.sv
verilog/apb_resp_mux.sv
verilog/pwm_timer_subsystem.sv
tests/tb_pwm_timer_subsystem.sv

// ==== tests/pwm_cases.txt ====
# name op addr data pslverr, with addr and data in hex
# op W writes, R reads and compares data, E compares pwm_o, P counts high cycles of addr's slot
rst_ctrl0      R 00000000 00000000 0
rst_period0    R 00000004 00000000 0
rst_duty0      R 00000008 00000000 0
rst_count0     R 0000000c 00000000 0
rst_ctrl3      R 00000030 00000000 0
rst_pwm        E 00000000 00000000 0
wr_period0     W 00000004 00000008 0
wr_duty0       W 00000008 12340003 0
rd_period0     R 00000004 00000008 0
rd_duty0       R 00000008 00000003 0
wr_ctrl1       W 00000010 ffffffff 0
rd_ctrl1       R 00000010 00000003 0
iso_ctrl0      R 00000000 00000000 0
iso_period1    R 00000014 00000000 0
dis_ctrl1      W 00000010 00000002 0
dis_count1_a   R 0000001c 00000000 0
dis_count1_b   R 0000001c 00000000 0
dis_pwm        E 00000000 00000002 0
miss_wr        W 00000040 0000ffff 1
miss_rd        R 00000080 00000000 1
miss_top       R fffffff0 00000000 1
cnt_wr0        W 0000000c 00000005 1
cnt_rd0        R 0000000c 00000000 0
keep_ctrl0     R 00000000 00000000 0
keep_period0   R 00000004 00000008 0
en_ctrl0       W 00000000 00000001 0
pwm_ch0        P 00000000 00000003 0
pol_ctrl0      W 00000000 00000003 0
pwm_ch0_pol    P 00000000 00000005 0
wr_period2     W 00000024 0000000a 0
wr_duty2       W 00000028 00000014 0
en_ctrl2       W 00000020 00000001 0
pwm_ch2_full   P 00000020 0000000a 0
wr_period3     W 00000034 00000000 0
wr_duty3       W 00000038 00000001 0
en_ctrl3       W 00000030 00000001 0
pwm_ch3_p0     P 00000030 00000001 0
rd_count3      R 0000003c 00000000 0
wr_period1     W 00000014 0000000c 0
wr_duty1       W 00000018 00000004 0
en_ctrl1       W 00000010 00000001 0
pwm_ch1        P 00000010 00000004 0
wr_period3b    W 00000034 00000010 0
pwm_ch3        P 00000030 00000001 0
en_ctrl0_b     W 00000000 00000001 0

// ==== tests/tb_pwm_timer_subsystem.sv ====
// Self-checking testbench for the PWM timer subsystem that runs the APB operations of tests/pwm_cases.txt
module tb_pwm_timer_subsystem;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_CASES       = 64;
   localparam int CLK_PERIOD      = 100;
   localparam int DRIVE_DELAY     = 10;
   localparam int HANDSHAKE_LIMIT = 8;
   localparam int NT              = apb_map_pkg::NUM_TIMERS;
   localparam int CW              = pwm_timer_pkg::CNT_W;

   logic          clk_i;
   logic          rst_i;
   logic [31:0]   paddr_i;
   logic          psel_i;
   logic          penable_i;
   logic          pwrite_i;
   logic [31:0]   pwdata_i;
   logic [31:0]   prdata_o;
   logic          pready_o;
   logic          pslverr_o;
   logic [NT-1:0] pwm_o;

   // Operations as read from the cases file
   logic [8*24-1:0] case_name [MAX_CASES];
   logic [7:0]      case_op   [MAX_CASES];
   logic [31:0]     case_addr [MAX_CASES];
   logic [31:0]     case_data [MAX_CASES];
   logic            case_err  [MAX_CASES];
   int              num_cases;
   logic            cases_loaded;

   // PERIOD and DUTY as the testbench expects them per channel
   logic [CW-1:0] period_model [NT];
   logic [CW-1:0] duty_model   [NT];

   int     check_cnt;
   int     err_cnt;
   int     proto_cnt;
   integer seed;

   pwm_timer_subsystem DUT (
      .clk_i     ( clk_i     ),
      .rst_i     ( rst_i     ),
      .paddr_i   ( paddr_i   ),
      .psel_i    ( psel_i    ),
      .penable_i ( penable_i ),
      .pwrite_i  ( pwrite_i  ),
      .pwdata_i  ( pwdata_i  ),
      .prdata_o  ( prdata_o  ),
      .pready_o  ( pready_o  ),
      .pslverr_o ( pslverr_o ),
      .pwm_o     ( pwm_o     )
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   task automatic next_drive_point;
      @(posedge clk_i);
      #(DRIVE_DELAY);
   endtask

   task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_cnt++;
      assert (actual === expected) else begin
         $display("CHECK FAILED %0s: expected %h, actual %h", name, expected, actual);
         err_cnt++;
      end
   endtask

   // Setup and access phase, then wait for pready before the completing edge
   task automatic apb_transfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic slverr);
      int waits;
      waits = 0;
      next_drive_point();
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = write;
      paddr_i   = addr;
      pwdata_i  = write ? wdata : '0;
      next_drive_point();
      penable_i = 1'b1;
      #(CLK_PERIOD / 2 - DRIVE_DELAY);
      // Zero wait states, so pready is already high in the first access cycle
      assert (pready_o) else begin
         $display("Transfer to address %h was not ready in its first access cycle",
                  addr);
         proto_cnt++;
      end
      while (!pready_o && waits < HANDSHAKE_LIMIT) begin
         @(posedge clk_i);
         #(CLK_PERIOD / 2);
         waits++;
      end
      assert (pready_o) else begin
         $display("Transfer to address %h never completed, pready stayed low", addr);
         proto_cnt++;
      end
      rdata  = prdata_o;
      slverr = pslverr_o;
      next_drive_point();
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   // Only in-map writes to PERIOD or DUTY change what a channel counts with
   task automatic update_model(input logic [31:0] addr, input logic [31:0] data);
      int ch;
      ch = addr[5:4];
      if (addr < apb_map_pkg::MAP_LIMIT) begin
         if (addr[3:0] == apb_map_pkg::REG_PERIOD) period_model[ch] = data[CW-1:0];
         if (addr[3:0] == apb_map_pkg::REG_DUTY) duty_model[ch] = data[CW-1:0];
      end
   endtask

   function automatic int span_of(input logic [CW-1:0] period);
      return (period == 0) ? 1 : int'(period);
   endfunction

   // High cycles per window are min(duty, period)
   function automatic logic [31:0] expected_high(input int ch);
      int span;
      span = span_of(period_model[ch]);
      return (int'(duty_model[ch]) < span) ? 32'(duty_model[ch]) : 32'(span);
   endfunction

   task automatic measure_high(input int ch, input int len, output logic [31:0] high);
      // Let a counter past a shrunken period wrap first
      repeat (2) @(posedge clk_i);
      high = 0;
      for (int i = 0; i < len; i++) begin
         next_drive_point();
         if (pwm_o[ch]) high++;
      end
   endtask

   task automatic load_cases;
      integer           fd;
      integer           n;
      logic [8*160-1:0] line_buf;
      logic [8*24-1:0]  name;
      logic [7:0]       op;
      logic [31:0]      addr;
      logic [31:0]      data;
      logic [31:0]      err;
      num_cases = 0;
      fd = $fopen("tests/pwm_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open the cases file tests/pwm_cases.txt");
         proto_cnt++;
      end else begin
         while (!$feof(fd) && num_cases < MAX_CASES) begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            // Comment lines do not parse into five fields
            if (n > 0) begin
               n = $sscanf(line_buf, "%s %s %h %h %h", name, op, addr, data, err);
               if (n == 5) begin
                  case_name[num_cases] = name;
                  case_op[num_cases]   = op;
                  case_addr[num_cases] = addr;
                  case_data[num_cases] = data;
                  case_err[num_cases]  = err[0];
                  num_cases++;
               end
            end
         end
         $fclose(fd);
      end
      cases_loaded = 1'b1;
   endtask

   task automatic run_case(input int idx);
      logic [31:0] rdata;
      logic        slverr;
      logic [31:0] high;
      int          ch;
      ch = case_addr[idx][5:4];
      case (case_op[idx])
         "W": begin
            apb_transfer(1'b1, case_addr[idx], case_data[idx], rdata, slverr);
            check_value(case_name[idx], 32'(case_err[idx]), 32'(slverr));
            update_model(case_addr[idx], case_data[idx]);
         end
         "R": begin
            apb_transfer(1'b0, case_addr[idx], '0, rdata, slverr);
            check_value(case_name[idx], case_data[idx], rdata);
            check_value(case_name[idx], 32'(case_err[idx]), 32'(slverr));
         end
         "E": begin
            next_drive_point();
            check_value(case_name[idx], case_data[idx], 32'(pwm_o));
         end
         "P": begin
            measure_high(ch, span_of(period_model[ch]), high);
            check_value(case_name[idx], case_data[idx], high);
         end
         default: begin
            $display("Case %0s has an unknown operation and was not run", case_name[idx]);
            proto_cnt++;
         end
      endcase
   endtask

   // Random DUTY on every channel, then the high time of each against the model
   task automatic random_duty_burst;
      logic [31:0] duty;
      logic [31:0] addr;
      logic [31:0] rdata;
      logic        slverr;
      logic [31:0] high;
      for (int ch = 0; ch < NT; ch++) begin
         duty = $random(seed) & 32'h0000_001f;
         addr = (ch << apb_map_pkg::SLOT_LSB) | apb_map_pkg::REG_DUTY;
         apb_transfer(1'b1, addr, duty, rdata, slverr);
         update_model(addr, duty);
         check_value("rnd_duty_wr", 32'h0, 32'(slverr));
         apb_transfer(1'b0, addr, '0, rdata, slverr);
         check_value("rnd_duty_rd", duty, rdata);
      end
      for (int ch = 0; ch < NT; ch++) begin
         measure_high(ch, span_of(period_model[ch]), high);
         check_value("rnd_pwm_high", expected_high(ch), high);
      end
   endtask

   // Channel 1 still has a nonzero period, so a running counter would show in COUNT
   task automatic disabled_count_check;
      logic [31:0] base;
      logic [31:0] rdata;
      logic        slverr;
      base = 32'(1) << apb_map_pkg::SLOT_LSB;
      apb_transfer(1'b1, base | apb_map_pkg::REG_CTRL, 32'h2, rdata, slverr);
      check_value("dis_wr_ctrl1", 32'h0, 32'(slverr));
      repeat (3) begin
         apb_transfer(1'b0, base | apb_map_pkg::REG_COUNT, '0, rdata, slverr);
         check_value("dis_count1", 32'h0, rdata);
      end
      check_value("dis_pwm1_pol", 32'h1, 32'(pwm_o[1]));
   endtask

   initial begin
      wait (cases_loaded);
      #((num_cases * 40 + 200) * CLK_PERIOD);
      $display("Watchdog expired, the run hung and did not reach its end");
      $display("** FAIL **");
      $finish;
   end

   initial begin
      rst_i        = 1'b1;
      paddr_i      = '0;
      psel_i       = 1'b0;
      penable_i    = 1'b0;
      pwrite_i     = 1'b0;
      pwdata_i     = '0;
      check_cnt    = 0;
      err_cnt      = 0;
      proto_cnt    = 0;
      seed         = 32'hf8c8;
      cases_loaded = 1'b0;
      for (int ch = 0; ch < NT; ch++) begin
         period_model[ch] = '0;
         duty_model[ch]   = '0;
      end
      load_cases();
      repeat (4) @(posedge clk_i);
      #(DRIVE_DELAY);
      rst_i = 1'b0;
      for (int idx = 0; idx < num_cases; idx++) begin
         run_case(idx);
      end
      random_duty_burst();
      disabled_count_check();
      $display("%0d cases, %0d checks, %0d value errors, %0d other errors",
               num_cases, check_cnt, err_cnt, proto_cnt);
      if (err_cnt == 0 && proto_cnt == 0 && num_cases > 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== verilog/apb_map_pkg.sv ====
// APB address map of the timer subsystem, shared by the decoder, channels, response mux and top
package apb_map_pkg;

   // Bus widths
   localparam int unsigned APB_ADDR_W = 32;
   localparam int unsigned APB_DATA_W = 32;

   // Number of timer channel slots behind the APB port
   localparam int unsigned NUM_TIMERS = 4;

   // Slot index sits right above the register offset, so every slot spans 16 bytes
   localparam int unsigned SLOT_LSB = 4;
   localparam int unsigned SLOT_W   = 2;

   // Register offsets inside one slot
   localparam logic [SLOT_LSB-1:0] REG_CTRL   = 4'h0;
   localparam logic [SLOT_LSB-1:0] REG_PERIOD = 4'h4;
   localparam logic [SLOT_LSB-1:0] REG_DUTY   = 4'h8;

   // Free-running counter, read only
   localparam logic [SLOT_LSB-1:0] REG_COUNT  = 4'hC;

   // First address past the last slot
   localparam logic [APB_ADDR_W-1:0] MAP_LIMIT = 32'h0000_0040;

endpackage

// ==== verilog/apb_resp_mux.sv ====
// Response mux that returns the addressed slot's APB reply, or an error for unmapped addresses
module apb_resp_mux (
   input  logic                                                        psel_i,
   input  logic                                                        penable_i,
   input  logic [apb_map_pkg::SLOT_W-1:0]                              slot_idx_i,
   input  logic                                                        miss_i,

   // One reply per slot
   input  logic [apb_map_pkg::NUM_TIMERS-1:0][apb_map_pkg::APB_DATA_W-1:0] prdata_i,
   input  logic [apb_map_pkg::NUM_TIMERS-1:0]                          pready_i,
   input  logic [apb_map_pkg::NUM_TIMERS-1:0]                          pslverr_i,

   // Reply towards the master
   output logic [apb_map_pkg::APB_DATA_W-1:0]                          prdata_o,
   output logic                                                        pready_o,
   output logic                                                        pslverr_o
);

   logic access;

   assign access = psel_i && penable_i;

   always_comb begin
      if (miss_i) begin
         // Nobody owns the address, so answer here with an error and no data
         prdata_o  = '0;
         pready_o  = access;
         pslverr_o = access;
      end else begin
         // Unselected slots hold their replies low, so idle cycles stay quiet
         prdata_o  = prdata_i[slot_idx_i];
         pready_o  = pready_i[slot_idx_i];
         pslverr_o = pslverr_i[slot_idx_i];
      end
   end

endmodule

// ==== verilog/apb_slot_decoder.sv ====
// Address decoder that turns the shared APB address into one select per timer slot
module apb_slot_decoder (
   input  logic [apb_map_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic                               psel_i,
   output logic [apb_map_pkg::NUM_TIMERS-1:0] slot_sel_o,
   output logic [apb_map_pkg::SLOT_W-1:0]     slot_idx_o,
   output logic                               miss_o
);

   logic                           in_range;
   logic [apb_map_pkg::SLOT_W-1:0] slot_idx;

   // Everything from MAP_LIMIT upwards belongs to no slot
   assign in_range = (paddr_i < apb_map_pkg::MAP_LIMIT);

   // Slot field of the address
   assign slot_idx = paddr_i[apb_map_pkg::SLOT_LSB +: apb_map_pkg::SLOT_W];

   // One-hot select, only while the master addresses the subsystem
   always_comb begin
      slot_sel_o = '0;
      if (psel_i && in_range) begin
         for (int unsigned i = 0; i < apb_map_pkg::NUM_TIMERS; i++) begin
            if (slot_idx == i[apb_map_pkg::SLOT_W-1:0]) begin
               slot_sel_o[i] = 1'b1;
            end
         end
      end
   end

   // Index goes to the response mux as is, the mux qualifies it with the miss flag
   assign slot_idx_o = slot_idx;

   // Selected but outside the map
   assign miss_o = psel_i && !in_range;

endmodule

// ==== verilog/pwm_timer_channel.sv ====
// One PWM timer channel with its APB register file, free-running counter and pad output
module pwm_timer_channel (
   input  logic                               clk_i,
   input  logic                               rst_i,

   // APB slave side, sel_i comes from the slot decoder
   input  logic                               sel_i,
   input  logic                               penable_i,
   input  logic                               pwrite_i,
   input  logic [apb_map_pkg::SLOT_LSB-1:0]   paddr_i,
   input  logic [apb_map_pkg::APB_DATA_W-1:0] pwdata_i,
   output logic [apb_map_pkg::APB_DATA_W-1:0] prdata_o,
   output logic                               pready_o,
   output logic                               pslverr_o,

   // Timer output towards the pad
   output logic                               pwm_o
);

   logic [pwm_timer_pkg::CTRL_W-1:0] ctrl_q;
   logic [pwm_timer_pkg::CNT_W-1:0]  period_q;
   logic [pwm_timer_pkg::CNT_W-1:0]  duty_q;
   logic [pwm_timer_pkg::CNT_W-1:0]  count_q;
   logic [pwm_timer_pkg::CNT_W-1:0]  count_last;

   logic access;
   logic wr_err;
   logic wr_en;
   logic rd_en;
   logic enable;
   logic polarity;
   logic active;

   logic [apb_map_pkg::APB_DATA_W-1:0] rdata;

   // Access phase of a transfer to this slot
   assign access = sel_i && penable_i;

   // COUNT is read only, a write there is refused
   assign wr_err = access && pwrite_i && (paddr_i == apb_map_pkg::REG_COUNT);
   assign wr_en  = access && pwrite_i && !wr_err;
   assign rd_en  = access && !pwrite_i;

   // No wait states
   assign pready_o  = access;
   assign pslverr_o = wr_err;

   // Register writes land on the completing edge
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctrl_q   <= pwm_timer_pkg::CTRL_RST;
         period_q <= pwm_timer_pkg::PERIOD_RST;
         duty_q   <= pwm_timer_pkg::DUTY_RST;
      end else if (wr_en) begin
         case (paddr_i)
            apb_map_pkg::REG_CTRL:   ctrl_q   <= pwdata_i[pwm_timer_pkg::CTRL_W-1:0];
            apb_map_pkg::REG_PERIOD: period_q <= pwdata_i[pwm_timer_pkg::CNT_W-1:0];
            apb_map_pkg::REG_DUTY:   duty_q   <= pwdata_i[pwm_timer_pkg::CNT_W-1:0];
            default: ;
         endcase
      end
   end

   assign enable   = ctrl_q[pwm_timer_pkg::CTRL_EN_BIT];
   assign polarity = ctrl_q[pwm_timer_pkg::CTRL_POL_BIT];

   // A period of zero behaves like a period of one
   assign count_last = (period_q == '0) ? '0 : period_q - 1'b1;

   // Counter wraps at period minus one and sits at zero while disabled.
   // The >= compare also catches a period that shrank below the current count
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= pwm_timer_pkg::COUNT_RST;
      end else if (!enable) begin
         count_q <= '0;
      end else if (count_q >= count_last) begin
         count_q <= '0;
      end else begin
         count_q <= count_q + 1'b1;
      end
   end

   // High while the count is below duty, then flipped by polarity
   assign active = enable && (count_q < duty_q);
   assign pwm_o  = active ^ polarity;

   // Read back, zero-extended to the bus width
   always_comb begin
      rdata = '0;
      if (rd_en) begin
         case (paddr_i)
            apb_map_pkg::REG_CTRL:   rdata[pwm_timer_pkg::CTRL_W-1:0] = ctrl_q;
            apb_map_pkg::REG_PERIOD: rdata[pwm_timer_pkg::CNT_W-1:0]  = period_q;
            apb_map_pkg::REG_DUTY:   rdata[pwm_timer_pkg::CNT_W-1:0]  = duty_q;
            apb_map_pkg::REG_COUNT:  rdata[pwm_timer_pkg::CNT_W-1:0]  = count_q;
            default: ;
         endcase
      end
   end

   assign prdata_o = rdata;

endmodule

// ==== verilog/pwm_timer_pkg.sv ====
// Layout and reset values of one PWM timer channel, used by the channel register file
package pwm_timer_pkg;

   // Counter, period and duty share one width
   localparam int unsigned CNT_W = 16;

   // Control register bits
   localparam int unsigned CTRL_EN_BIT  = 0;
   localparam int unsigned CTRL_POL_BIT = 1;

   // Only these low control bits are stored, the rest read back as zero
   localparam int unsigned CTRL_W = 2;

   // Reset values of the channel registers
   localparam logic [CTRL_W-1:0] CTRL_RST   = '0;
   localparam logic [CNT_W-1:0]  PERIOD_RST = '0;
   localparam logic [CNT_W-1:0]  DUTY_RST   = '0;
   localparam logic [CNT_W-1:0]  COUNT_RST  = '0;

endpackage

// ==== verilog/pwm_timer_subsystem.sv ====
// Top of the APB timer subsystem: slot decoder, a bank of PWM channels and the response mux
module pwm_timer_subsystem (
   input  logic                               clk_i,
   input  logic                               rst_i,

   // APB slave port
   input  logic [apb_map_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic                               psel_i,
   input  logic                               penable_i,
   input  logic                               pwrite_i,
   input  logic [apb_map_pkg::APB_DATA_W-1:0] pwdata_i,
   output logic [apb_map_pkg::APB_DATA_W-1:0] prdata_o,
   output logic                               pready_o,
   output logic                               pslverr_o,

   // Timer outputs to the pads, one per channel
   output logic [apb_map_pkg::NUM_TIMERS-1:0] pwm_o
);

   logic [apb_map_pkg::NUM_TIMERS-1:0]                          slot_sel;
   logic [apb_map_pkg::SLOT_W-1:0]                              slot_idx;
   logic                                                        miss;
   logic [apb_map_pkg::NUM_TIMERS-1:0][apb_map_pkg::APB_DATA_W-1:0] ch_prdata;
   logic [apb_map_pkg::NUM_TIMERS-1:0]                          ch_pready;
   logic [apb_map_pkg::NUM_TIMERS-1:0]                          ch_pslverr;

   apb_slot_decoder i_apb_slot_decoder (
      .paddr_i    ( paddr_i  ),
      .psel_i     ( psel_i   ),
      .slot_sel_o ( slot_sel ),
      .slot_idx_o ( slot_idx ),
      .miss_o     ( miss     )
   );

   // Channels only see the offset bits of the address
   for (genvar i = 0; i < apb_map_pkg::NUM_TIMERS; i++) begin : g_timer
      pwm_timer_channel i_pwm_timer_channel (
         .clk_i     ( clk_i                                 ),
         .rst_i     ( rst_i                                 ),
         .sel_i     ( slot_sel[i]                           ),
         .penable_i ( penable_i                             ),
         .pwrite_i  ( pwrite_i                              ),
         .paddr_i   ( paddr_i[apb_map_pkg::SLOT_LSB-1:0]    ),
         .pwdata_i  ( pwdata_i                              ),
         .prdata_o  ( ch_prdata[i]                          ),
         .pready_o  ( ch_pready[i]                          ),
         .pslverr_o ( ch_pslverr[i]                         ),
         .pwm_o     ( pwm_o[i]                              )
      );
   end

   apb_resp_mux i_apb_resp_mux (
      .psel_i     ( psel_i     ),
      .penable_i  ( penable_i  ),
      .slot_idx_i ( slot_idx   ),
      .miss_i     ( miss       ),
      .prdata_i   ( ch_prdata  ),
      .pready_i   ( ch_pready  ),
      .pslverr_i  ( ch_pslverr ),
      .prdata_o   ( prdata_o   ),
      .pready_o   ( pready_o   ),
      .pslverr_o  ( pslverr_o  )
   );

endmodule
